//--- include/tlk2711_tx_defines.svh
// code words are {msb byte, lsb byte}; FIFO depth must be a power of two; no timescale here
`ifndef TLK2711_TX_DEFINES_SVH
`define TLK2711_TX_DEFINES_SVH

// bus widths
`define TX_DMA_WIDTH        64
`define TX_WORD_WIDTH       16

// buffer depth in 64-bit beats
`define TX_FIFO_DEPTH       512

// word counts
`define TX_SYNC_WORDS       6
`define TX_NORM_GAP_WORDS   257

////////////////////
// K and D code pairs
`define TX_IDLE_WORD        16'hC5BC
`define TX_SOF_WORD         16'h5CFB
`define TX_EOF_WORD         16'hFDFE

////////////////////
// frame header and file-sign bytes
`define TX_HEAD0            16'hEB90
`define TX_HEAD1            16'hE116
`define TX_IND_BYTE         8'h81
`define TX_FILE_END_BYTE    8'h01

`endif

//--- verilog/tlk2711_tx_pkg.sv
// only normal and specific modes are framed; every other mode code leaves the link idle
package tlk2711_tx_pkg;

    // transfer mode, encodings follow the host register map
    typedef enum logic [2:0] {
        mode_normal   = 3'd0,
        mode_kcode    = 3'd1,
        mode_test     = 3'd2,
        mode_specific = 3'd3,
        mode_proto    = 3'd4
    } tx_mode_e;

    // framer states, in order of transmission
    typedef enum logic [3:0] {
        st_idle = 4'd0,
        st_sync = 4'd1,
        st_sof  = 4'd2,
        st_head = 4'd3,
        st_sign = 4'd4,
        st_fnum = 4'd5,
        st_len  = 4'd6,
        st_data = 4'd7,
        st_csum = 4'd8,
        st_eof  = 4'd9,
        st_gap  = 4'd10,
        st_intr = 4'd11
    } tx_state_e;

    // file-sign word, decoded per mode
    typedef union packed {
        struct packed {
            logic [7:0] type_byte;
            logic [7:0] end_byte;
        } norm;
        struct packed {
            logic       zero_hi;
            logic       file_end;
            logic       zero_lo;
            logic       channel_id;
            logic [3:0] sweep;
            logic [7:0] frame_hi;
        } spec;
    } tx_sign_word_u;

endpackage

//--- verilog/tlk2711_tx_if.sv
// word path from buffer to framer; a read consumes the shown word on the same clock edge
`timescale 1ns/1ps
`include "tlk2711_tx_defines.svh"

interface tx_word_if;

    // current 16-bit lane, fall-through
    logic [`TX_WORD_WIDTH-1:0] word;
    // high while the buffer is not empty
    logic                      word_valid;
    // framer takes the shown word
    logic                      word_rd;
    // drop the rest of the current 64-bit entry
    logic                      frame_end;

    modport fifo (
        output word,
        output word_valid,
        input  word_rd,
        input  frame_end
    );

    modport framer (
        input  word,
        input  word_valid,
        output word_rd,
        output frame_end
    );

endinterface

//--- verilog/tlk2711_tx_session.sv
// one transfer per start edge; mode is sampled once, and DMA writes stay off in non-framed modes
`timescale 1ns/1ps
`include "tlk2711_tx_defines.svh"

module tlk2711_tx_session
    import tlk2711_tx_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_soft_reset,

    input  logic                     i_tx_start,
    input  tx_mode_e                 i_tx_mode,

    input  logic                     i_dma_rd_valid,
    input  logic [`TX_DMA_WIDTH-1:0] i_dma_rd_data,

    input  logic                     i_fifo_full,
    input  logic                     i_gap_entered,

    output logic                     o_fifo_wr,
    output logic [`TX_DMA_WIDTH-1:0] o_fifo_wdata,
    output tx_mode_e                 o_mode,
    output logic                     o_armed
);

    logic start_d;
    logic start_pulse;
    logic wr_enable;

    ////////////////////
    // start edge, registered once
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            start_d     <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            start_d     <= i_tx_start;
            start_pulse <= i_tx_start & ~start_d;
        end
    end

    ////////////////////
    // mode latch, write enable and armed flag
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_mode    <= mode_normal;
            wr_enable <= 1'b0;
            o_armed   <= 1'b0;
        end else begin
            if (start_pulse) begin
                o_mode    <= i_tx_mode;
                wr_enable <= (i_tx_mode == mode_normal) || (i_tx_mode == mode_specific);
            end

            // framer takes the arm at its first gap
            if (start_pulse) begin
                o_armed <= 1'b1;
            end else if (i_gap_entered) begin
                o_armed <= 1'b0;
            end
        end
    end

    // a beat goes in only when enabled and there is room
    assign o_fifo_wr    = i_dma_rd_valid & wr_enable & ~i_fifo_full;
    assign o_fifo_wdata = i_dma_rd_data;

endmodule

//--- verilog/tlk2711_tx_fifo.sv
// 64-bit in, 16-bit out, low lane first; a frame-end pulse on a fresh entry keeps that entry
`timescale 1ns/1ps
`include "tlk2711_tx_defines.svh"

module tlk2711_tx_fifo (
    input  logic                     clk,
    input  logic                     i_soft_reset,

    input  logic                     i_wr,
    input  logic [`TX_DMA_WIDTH-1:0] i_wdata,
    output logic                     o_full,

    tx_word_if.fifo                  rd
);

    localparam int AW    = $clog2(`TX_FIFO_DEPTH);
    localparam int LANES = `TX_DMA_WIDTH / `TX_WORD_WIDTH;
    localparam int LW    = $clog2(LANES);

    logic [`TX_DMA_WIDTH-1:0] mem [`TX_FIFO_DEPTH];

    // extra top bit tells full from empty
    logic [AW:0]              wr_ptr;
    logic [AW:0]              rd_ptr;
    logic [LW-1:0]            lane;

    logic [`TX_DMA_WIDTH-1:0] head;
    logic                     empty;
    logic                     push;
    logic                     pop;
    logic                     last_lane;

    assign empty  = (wr_ptr == rd_ptr);
    assign o_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign push   = i_wr & ~o_full;

    ////////////////////
    // entry pop and lane select
    assign last_lane = (lane == LW'(LANES - 1));

    // frame end drops only a partly read entry
    assign pop = ~empty & ((rd.word_rd & last_lane) | (rd.frame_end & (lane != '0)));

    assign head          = mem[rd_ptr[AW-1:0]];
    assign rd.word       = head[lane * `TX_WORD_WIDTH +: `TX_WORD_WIDTH];
    assign rd.word_valid = ~empty;

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // lane pointer restarts with every new entry
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            lane <= '0;
        end else if (pop) begin
            lane <= '0;
        end else if (rd.word_rd && !empty) begin
            lane <= lane + 1'b1;
        end
    end

endmodule

//--- verilog/tlk2711_tx_framer.sv
// stream never stalls, an underrun repeats the last word; gap and interrupt widths must be nonzero
`timescale 1ns/1ps
`include "tlk2711_tx_defines.svh"

module tlk2711_tx_framer
    import tlk2711_tx_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_soft_reset,

    input  tx_mode_e                  i_mode,
    input  logic                      i_armed,

    input  logic [15:0]               i_tx_packet_body,
    input  logic [15:0]               i_tx_packet_tail,
    input  logic [23:0]               i_tx_body_num,
    input  logic [19:0]               i_backward_cycle_num,
    input  logic [15:0]               i_tx_intr_width,

    tx_word_if.framer                 rd,

    output logic                      o_gap_entered,
    output logic                      o_tx_interrupt,
    output logic                      o_2711_tkmsb,
    output logic                      o_2711_tklsb,
    output logic [`TX_WORD_WIDTH-1:0] o_2711_txd
);

    tx_state_e                 state;
    tx_state_e                 state_next;

    logic [3:0]                sync_cnt;
    logic                      head_sel;
    logic [14:0]               data_cnt;
    logic [19:0]               gap_cnt;
    logic [15:0]               intr_cnt;
    logic [23:0]               frame_cnt;
    logic [15:0]               frame_len;
    logic [15:0]               csum;
    logic                      channel_id;

    logic                      framed;
    logic                      is_last;
    logic [19:0]               gap_len;
    logic                      gap_done;
    logic                      intr_done;
    tx_sign_word_u             sign_w;

    logic [`TX_WORD_WIDTH-1:0] word_c;
    logic                      kmsb_c;
    logic                      klsb_c;

    assign framed    = (i_mode == mode_normal) || (i_mode == mode_specific);
    assign is_last   = (frame_cnt == i_tx_body_num);
    assign gap_len   = (i_mode == mode_specific) ? i_backward_cycle_num
                                                 : 20'(`TX_NORM_GAP_WORDS);
    assign gap_done  = (gap_cnt == gap_len - 20'd1);
    assign intr_done = (intr_cnt == i_tx_intr_width - 16'd1);

    assign rd.word_rd     = (state == st_data);
    assign rd.frame_end   = (state == st_csum);
    assign o_gap_entered  = (state == st_eof);

    ////////////////////
    // file-sign word, one view per mode
    always_comb begin
        if (i_mode == mode_specific) begin
            sign_w.spec.zero_hi    = 1'b0;
            sign_w.spec.file_end   = is_last;
            sign_w.spec.zero_lo    = 1'b0;
            sign_w.spec.channel_id = channel_id;
            // sweep code
            sign_w.spec.sweep      = 4'd1;
            sign_w.spec.frame_hi   = frame_cnt[23:16];
        end else begin
            sign_w.norm.type_byte  = `TX_IND_BYTE;
            sign_w.norm.end_byte   = is_last ? `TX_FILE_END_BYTE : 8'h00;
        end
    end

    ////////////////////
    // next state and next word
    always_comb begin
        state_next = state;
        word_c     = `TX_IDLE_WORD;
        kmsb_c     = 1'b0;
        klsb_c     = 1'b1;
        case (state)
            st_idle: begin
                if (i_armed && rd.word_valid) begin
                    state_next = st_sync;
                end
            end
            st_sync: begin
                if (sync_cnt == 4'(`TX_SYNC_WORDS - 1)) begin
                    state_next = st_sof;
                end
            end
            st_sof: begin
                word_c     = `TX_SOF_WORD;
                kmsb_c     = 1'b1;
                state_next = st_head;
            end
            st_head: begin
                word_c = head_sel ? `TX_HEAD1 : `TX_HEAD0;
                klsb_c = 1'b0;
                if (head_sel) begin
                    state_next = st_sign;
                end
            end
            st_sign: begin
                word_c     = sign_w;
                klsb_c     = 1'b0;
                state_next = st_fnum;
            end
            st_fnum: begin
                word_c     = frame_cnt[15:0];
                klsb_c     = 1'b0;
                state_next = st_len;
            end
            st_len: begin
                word_c     = frame_len;
                klsb_c     = 1'b0;
                // fewer than two bytes means no data words
                state_next = (frame_len[15:1] == 15'd0) ? st_csum : st_data;
            end
            st_data: begin
                // underrun repeats the word already on the pins
                word_c = rd.word_valid ? rd.word : o_2711_txd;
                klsb_c = 1'b0;
                if (data_cnt == frame_len[15:1] - 15'd1) begin
                    state_next = st_csum;
                end
            end
            st_csum: begin
                word_c     = csum;
                klsb_c     = 1'b0;
                state_next = st_eof;
            end
            st_eof: begin
                word_c     = `TX_EOF_WORD;
                kmsb_c     = 1'b1;
                state_next = st_gap;
            end
            st_gap: begin
                if (gap_done) begin
                    state_next = is_last ? st_intr : st_sof;
                end
            end
            st_intr: begin
                if (intr_done) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase

        // unsupported modes hold the link idle
        if (!framed) begin
            state_next = st_idle;
            word_c     = `TX_IDLE_WORD;
            kmsb_c     = 1'b0;
            klsb_c     = 1'b1;
        end
    end

    ////////////////////
    // state, counters and checksum
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state      <= st_idle;
            sync_cnt   <= '0;
            head_sel   <= 1'b0;
            data_cnt   <= '0;
            gap_cnt    <= '0;
            intr_cnt   <= '0;
            frame_cnt  <= '0;
            frame_len  <= '0;
            csum       <= '0;
            channel_id <= 1'b0;
        end else begin
            state    <= state_next;
            sync_cnt <= (state == st_sync) ? sync_cnt + 4'd1 : 4'd0;
            head_sel <= (state == st_head) ? ~head_sel : 1'b0;
            data_cnt <= (state == st_data) ? data_cnt + 15'd1 : 15'd0;
            gap_cnt  <= (state == st_gap) ? gap_cnt + 20'd1 : 20'd0;
            intr_cnt <= (state == st_intr) ? intr_cnt + 16'd1 : 16'd0;

            if (state == st_idle) begin
                frame_cnt <= '0;
            end else if (state == st_gap && gap_done) begin
                frame_cnt <= frame_cnt + 24'd1;
            end

            // tail length only in the last frame
            if (state == st_sof) begin
                frame_len <= is_last ? i_tx_packet_tail : i_tx_packet_body;
            end

            if (state == st_sof) begin
                csum <= '0;
            end else if (state == st_fnum || state == st_len || state == st_data) begin
                csum <= csum + word_c;
            end

            if (state == st_sign && i_mode == mode_specific) begin
                channel_id <= ~channel_id;
            end
        end
    end

    // pins follow the state decision by one cycle
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_2711_txd     <= `TX_IDLE_WORD;
            o_2711_tkmsb   <= 1'b0;
            o_2711_tklsb   <= 1'b1;
            o_tx_interrupt <= 1'b0;
        end else begin
            o_2711_txd     <= word_c;
            o_2711_tkmsb   <= kmsb_c;
            o_2711_tklsb   <= klsb_c;
            o_tx_interrupt <= (state == st_intr);
        end
    end

endmodule

//--- verilog/tlk2711_tx_top.sv
// all DMA beats of a transfer should be offered before the framer drains the buffer
`timescale 1ns/1ps
`include "tlk2711_tx_defines.svh"

module tlk2711_tx_top
    import tlk2711_tx_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_soft_reset,

    input  logic                      i_tx_start,
    input  tx_mode_e                  i_tx_mode,
    input  logic [15:0]               i_tx_packet_body,
    input  logic [15:0]               i_tx_packet_tail,
    input  logic [23:0]               i_tx_body_num,
    input  logic [19:0]               i_backward_cycle_num,
    input  logic [15:0]               i_tx_intr_width,

    // DMA read side
    input  logic                      i_dma_rd_valid,
    input  logic [`TX_DMA_WIDTH-1:0]  i_dma_rd_data,
    output logic                      o_dma_rd_ready,

    output logic                      o_tx_interrupt,
    output logic                      o_2711_tkmsb,
    output logic                      o_2711_tklsb,
    output logic [`TX_WORD_WIDTH-1:0] o_2711_txd
);

    logic                     fifo_wr;
    logic [`TX_DMA_WIDTH-1:0] fifo_wdata;
    logic                     fifo_full;
    tx_mode_e                 mode;
    logic                     armed;
    logic                     gap_entered;

    tx_word_if word_if ();

    assign o_dma_rd_ready = ~fifo_full;

    tlk2711_tx_session session0 (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_tx_mode      (i_tx_mode),
        .i_dma_rd_valid (i_dma_rd_valid),
        .i_dma_rd_data  (i_dma_rd_data),
        .i_fifo_full    (fifo_full),
        .i_gap_entered  (gap_entered),
        .o_fifo_wr      (fifo_wr),
        .o_fifo_wdata   (fifo_wdata),
        .o_mode         (mode),
        .o_armed        (armed)
    );

    tlk2711_tx_fifo fifo0 (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr         (fifo_wr),
        .i_wdata      (fifo_wdata),
        .o_full       (fifo_full),
        .rd           (word_if.fifo)
    );

    tlk2711_tx_framer framer0 (
        .clk                  (clk),
        .i_soft_reset         (i_soft_reset),
        .i_mode               (mode),
        .i_armed              (armed),
        .i_tx_packet_body     (i_tx_packet_body),
        .i_tx_packet_tail     (i_tx_packet_tail),
        .i_tx_body_num        (i_tx_body_num),
        .i_backward_cycle_num (i_backward_cycle_num),
        .i_tx_intr_width      (i_tx_intr_width),
        .rd                   (word_if.framer),
        .o_gap_entered        (gap_entered),
        .o_tx_interrupt       (o_tx_interrupt),
        .o_2711_tkmsb         (o_2711_tkmsb),
        .o_2711_tklsb         (o_2711_tklsb),
        .o_2711_txd           (o_2711_txd)
    );

endmodule

//--- tb/tlk2711_tx_tb_model.svh
// expected stream assumes no underrun and that every frame starts on a fresh DMA beat
`ifndef TLK2711_TX_TB_MODEL_SVH
`define TLK2711_TX_TB_MODEL_SVH

// one cycle of pins as {interrupt, tkmsb, tklsb, txd}
function automatic void push_word(input logic [15:0] word, input logic kmsb,
                                  input logic klsb, input logic irq);
    exp_stream.push_back({irq, kmsb, klsb, word});
endfunction

// file-sign word of one frame
function automatic logic [15:0] sign_word(input logic spec, input logic last,
                                          input logic chan, input int frame);
    logic [23:0] fn;
    fn = frame[23:0];
    if (spec) begin
        return {1'b0, last, 1'b0, chan, 4'h1, fn[23:16]};
    end
    return {`TX_IND_BYTE, last ? `TX_FILE_END_BYTE : 8'h00};
endfunction

////////////////////
// pins from the first SOF to one idle word after the interrupt
function automatic void build_expected(input logic spec, input int body, input int tail,
                                       input int count, input int gap, input int intr_w);
    int          frame;
    int          k;
    int          len;
    int          nwords;
    int          beat_base;
    logic        last;
    logic        chan;
    logic [15:0] sum;
    logic [15:0] w;
    logic [63:0] beat;
    exp_stream.delete();
    beat_base = 0;
    chan      = 1'b0;
    for (frame = 0; frame <= count; frame++) begin
        last   = (frame == count);
        len    = last ? tail : body;
        nwords = len / 2;
        // sum covers frame number, length and data
        sum    = frame[15:0] + len[15:0];
        push_word(`TX_SOF_WORD, 1'b1, 1'b1, 1'b0);
        push_word(`TX_HEAD0, 1'b0, 1'b0, 1'b0);
        push_word(`TX_HEAD1, 1'b0, 1'b0, 1'b0);
        push_word(sign_word(spec, last, chan, frame), 1'b0, 1'b0, 1'b0);
        push_word(frame[15:0], 1'b0, 1'b0, 1'b0);
        push_word(len[15:0], 1'b0, 1'b0, 1'b0);
        // low lane goes out first
        for (k = 0; k < nwords; k++) begin
            beat = beats[beat_base + k / 4];
            w    = beat[16 * (k % 4) +: 16];
            sum  = sum + w;
            push_word(w, 1'b0, 1'b0, 1'b0);
        end
        push_word(sum, 1'b0, 1'b0, 1'b0);
        push_word(`TX_EOF_WORD, 1'b1, 1'b1, 1'b0);
        // unread lanes of the last beat are dropped
        beat_base = beat_base + (nwords + 3) / 4;
        if (spec) begin
            chan = ~chan;
        end
        for (k = 0; k < gap; k++) begin
            push_word(`TX_IDLE_WORD, 1'b0, 1'b1, 1'b0);
        end
    end
    for (k = 0; k < intr_w; k++) begin
        push_word(`TX_IDLE_WORD, 1'b0, 1'b1, 1'b1);
    end
    push_word(`TX_IDLE_WORD, 1'b0, 1'b1, 1'b0);
endfunction

`endif

//--- tb/tlk2711_tx_tb.sv
// each table row starts from a soft reset; framed rows offer exactly the DMA beats their frames consume
`timescale 1ns/1ps
`include "tlk2711_tx_defines.svh"

module tlk2711_tx_tb
    import tlk2711_tx_pkg::*;
();

    localparam int NROWS         = 5;
    localparam int SOF_TIMEOUT   = 400;
    localparam int STALL_TIMEOUT = 4000;
    localparam int IDLE_CYCLES   = 40;

    logic                      clk;
    logic                      i_soft_reset;
    logic                      i_tx_start;
    tx_mode_e                  i_tx_mode;
    logic [15:0]               i_tx_packet_body;
    logic [15:0]               i_tx_packet_tail;
    logic [23:0]               i_tx_body_num;
    logic [19:0]               i_backward_cycle_num;
    logic [15:0]               i_tx_intr_width;
    logic                      i_dma_rd_valid;
    logic [`TX_DMA_WIDTH-1:0]  i_dma_rd_data;
    logic                      o_dma_rd_ready;
    logic                      o_tx_interrupt;
    logic                      o_2711_tkmsb;
    logic                      o_2711_tklsb;
    logic [`TX_WORD_WIDTH-1:0] o_2711_txd;

    int                        errors;
    int                        checks;
    logic                      aborted;
    logic                      saw_full;
    int unsigned               seed_ret;
    logic [`TX_DMA_WIDTH-1:0]  beats [$];
    logic [18:0]               exp_stream [$];

    ////////////////////
    // mode, body, tail, body count, gap, interrupt width, beats
    // row 2 offers more beats than the FIFO holds
    tx_mode_e row_mode  [NROWS] = '{mode_normal, mode_specific, mode_normal,
                                    mode_specific, mode_test};
    int       row_body  [NROWS] = '{64, 36, 2048, 8, 64};
    int       row_tail  [NROWS] = '{20, 6, 1000, 2, 64};
    int       row_count [NROWS] = '{2, 3, 3, 0, 1};
    int       row_gap   [NROWS] = '{0, 12, 0, 1, 5};
    int       row_intr  [NROWS] = '{4, 7, 16, 1, 3};
    int       row_beats [NROWS] = '{19, 16, 893, 1, 8};

    `include "tlk2711_tx_tb_model.svh"

    tlk2711_tx_top dut0 (
        .clk                  (clk),
        .i_soft_reset         (i_soft_reset),
        .i_tx_start           (i_tx_start),
        .i_tx_mode            (i_tx_mode),
        .i_tx_packet_body     (i_tx_packet_body),
        .i_tx_packet_tail     (i_tx_packet_tail),
        .i_tx_body_num        (i_tx_body_num),
        .i_backward_cycle_num (i_backward_cycle_num),
        .i_tx_intr_width      (i_tx_intr_width),
        .i_dma_rd_valid       (i_dma_rd_valid),
        .i_dma_rd_data        (i_dma_rd_data),
        .o_dma_rd_ready       (o_dma_rd_ready),
        .o_tx_interrupt       (o_tx_interrupt),
        .o_2711_tkmsb         (o_2711_tkmsb),
        .o_2711_tklsb         (o_2711_tklsb),
        .o_2711_txd           (o_2711_txd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want, input int row, input int idx);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h (row %0d, word %0d)",
                     name, got, want, row, idx);
        end
    endtask

    task automatic apply_reset();
        i_soft_reset   <= 1'b1;
        i_tx_start     <= 1'b0;
        i_dma_rd_valid <= 1'b0;
        repeat (5) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic start_transfer();
        @(posedge clk);
        i_tx_start <= 1'b1;
        // edge detect then mode latch and write enable
        repeat (3) @(posedge clk);
        i_tx_start <= 1'b0;
    endtask

    task automatic wait_for_sof(input int row, output logic found);
        int waited;
        waited = 0;
        found  = 1'b0;
        while (!found && !aborted) begin
            @(posedge clk);
            if (o_2711_tkmsb && o_2711_txd == `TX_SOF_WORD) begin
                found = 1'b1;
            end else begin
                waited++;
                if (waited > SOF_TIMEOUT) begin
                    $display("timeout: no SOF on the serializer pins in row %0d", row);
                    errors++;
                    aborted = 1'b1;
                end
            end
        end
    endtask

    ////////////////////
    // DMA driver with one beat per accepted edge
    task automatic send_beats(input int count);
        int sent;
        int stall;
        sent  = 0;
        stall = 0;
        if (count > 0) begin
            i_dma_rd_valid <= 1'b1;
            i_dma_rd_data  <= beats[0];
        end
        while (sent < count && !aborted) begin
            @(posedge clk);
            if (!o_dma_rd_ready) begin
                saw_full = 1'b1;
            end
            if (i_dma_rd_valid && o_dma_rd_ready) begin
                sent++;
                stall = 0;
            end else begin
                stall++;
            end
            if (stall > STALL_TIMEOUT) begin
                $display("timeout: o_dma_rd_ready stayed low for %0d cycles", STALL_TIMEOUT);
                errors++;
                aborted = 1'b1;
            end else if (sent < count) begin
                i_dma_rd_data <= beats[sent];
            end
        end
        i_dma_rd_valid <= 1'b0;
    endtask

    task automatic watch_stream(input int row);
        logic        found;
        logic [18:0] want;
        int          i;
        wait_for_sof(row, found);
        i = 0;
        while (found && i < exp_stream.size() && !aborted) begin
            if (i > 0) begin
                @(posedge clk);
            end
            want = exp_stream[i];
            check_value("o_2711_txd", o_2711_txd, want[15:0], row, i);
            check_value("o_2711_tklsb", o_2711_tklsb, want[16], row, i);
            check_value("o_2711_tkmsb", o_2711_tkmsb, want[17], row, i);
            check_value("o_tx_interrupt", o_tx_interrupt, want[18], row, i);
            i++;
        end
    endtask

    // link must hold the sync word with the low flag
    task automatic watch_idle(input int row, input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            check_value("o_2711_txd", o_2711_txd, `TX_IDLE_WORD, row, i);
            check_value("o_2711_tklsb", o_2711_tklsb, 1'b1, row, i);
            check_value("o_2711_tkmsb", o_2711_tkmsb, 1'b0, row, i);
            check_value("o_tx_interrupt", o_tx_interrupt, 1'b0, row, i);
        end
    endtask

    task automatic run_row(input int r);
        logic framed;
        logic spec;
        int   gap;
        int   i;
        framed = (row_mode[r] == mode_normal) || (row_mode[r] == mode_specific);
        spec   = (row_mode[r] == mode_specific);
        gap    = spec ? row_gap[r] : `TX_NORM_GAP_WORDS;
        apply_reset();
        beats.delete();
        for (i = 0; i < row_beats[r]; i++) begin
            beats.push_back({$urandom, $urandom});
        end
        if (framed) begin
            build_expected(spec, row_body[r], row_tail[r], row_count[r], gap, row_intr[r]);
        end
        i_tx_mode            <= row_mode[r];
        i_tx_packet_body     <= row_body[r][15:0];
        i_tx_packet_tail     <= row_tail[r][15:0];
        i_tx_body_num        <= row_count[r][23:0];
        i_backward_cycle_num <= row_gap[r][19:0];
        i_tx_intr_width      <= row_intr[r][15:0];
        start_transfer();
        if (framed) begin
            saw_full = 1'b0;
            fork
                send_beats(row_beats[r]);
                watch_stream(r);
            join
            if (row_beats[r] > `TX_FIFO_DEPTH) begin
                checks++;
                assert (saw_full) else begin
                    errors++;
                    $display("o_dma_rd_ready never dropped in row %0d with a full FIFO", r);
                end
            end
        end else begin
            // beats are offered but must not start a frame
            fork
                send_beats(row_beats[r]);
                watch_idle(r, IDLE_CYCLES);
            join
        end
    endtask

    ////////////////////
    // soft reset in the middle of a frame
    task automatic check_reset_recovery();
        logic found;
        int   i;
        apply_reset();
        beats.delete();
        for (i = 0; i < 8; i++) begin
            beats.push_back({$urandom, $urandom});
        end
        i_tx_mode        <= mode_normal;
        i_tx_packet_body <= 16'd64;
        i_tx_packet_tail <= 16'd64;
        i_tx_body_num    <= 24'd0;
        i_tx_intr_width  <= 16'd2;
        start_transfer();
        fork
            send_beats(8);
            wait_for_sof(NROWS, found);
        join
        repeat (3) @(posedge clk);
        apply_reset();
        watch_idle(NROWS, IDLE_CYCLES);
    endtask

    initial begin
        int r;
        errors               = 0;
        checks               = 0;
        aborted              = 1'b0;
        saw_full             = 1'b0;
        seed_ret             = $urandom(32'h3024);
        i_soft_reset         = 1'b1;
        i_tx_start           = 1'b0;
        i_tx_mode            = mode_normal;
        i_tx_packet_body     = '0;
        i_tx_packet_tail     = '0;
        i_tx_body_num        = '0;
        i_backward_cycle_num = '0;
        i_tx_intr_width      = '0;
        i_dma_rd_valid       = 1'b0;
        i_dma_rd_data        = '0;
        @(posedge clk);
        for (r = 0; r < NROWS && !aborted; r++) begin
            run_row(r);
        end
        if (!aborted) begin
            check_reset_recovery();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tlk2711_tx_top.f
+incdir+include
+incdir+tb
verilog/tlk2711_tx_pkg.sv
verilog/tlk2711_tx_if.sv
verilog/tlk2711_tx_session.sv
verilog/tlk2711_tx_fifo.sv
verilog/tlk2711_tx_framer.sv
verilog/tlk2711_tx_top.sv
tb/tlk2711_tx_tb.sv
